/* flist.f */
design/dram_geom_pkg.sv
design/dram_host_pkg.sv
design/dram_queue.sv
design/dram_bank.sv
design/dram_ctrl.sv
design/dram_subsys.sv
verification/dram_subsys_chk.sv
verification/dram_subsys_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= dram_subsys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/dram_subsys_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_subsys_tb;

    localparam int REQ_DEPTH        = 4;
    localparam int RSP_CREDITS      = 2;
    localparam int RSP_DEPTH        = 2;
    localparam int T_RCD            = 2;
    localparam int T_RP             = 2;
    localparam int NB               = dram_geom_pkg::NUM_BANKS;
    localparam int ROWS             = 2 ** dram_geom_pkg::ROW_W;
    localparam int COLS             = 2 ** dram_geom_pkg::COL_W;
    localparam logic [31:0] SEED    = 32'h322c_e1bf;
    localparam int MAX_CREDIT_DELAY = 6;    // Longest time the host keeps a response slot
    localparam int HOLD_CYCLES      = 80;   // Length of the response credit stall
    localparam int BP_FILL          = REQ_DEPTH + RSP_DEPTH + RSP_CREDITS;  // Fits during a stall
    localparam int RAND_REQS        = 300;
    localparam int TOTAL_REQS       = 4 * NB * COLS + 9 + BP_FILL + 4 + RAND_REQS;
    localparam int WORST_LAT        = T_RP + T_RCD + 6 + MAX_CREDIT_DELAY;  // Miss plus slot wait
    localparam int TIMEOUT_CYCLES   = 3 * (TOTAL_REQS * WORST_LAT + HOLD_CYCLES);

    logic                     clk;
    logic                     arst_n;
    logic                     req_valid;
    dram_host_pkg::host_req_t req;
    logic                     req_credit;
    logic                     rsp_valid;
    dram_host_pkg::host_rsp_t rsp;
    logic                     rsp_credit;

    logic [31:0]                     ref_mem      [NB][ROWS][COLS];  // Model of all cells
    bit                              ref_open_vld [NB];              // Model open-page table
    logic [dram_geom_pkg::ROW_W-1:0] ref_open_row [NB];
    bit                              written      [NB][ROWS][COLS];  // Cells with defined data
    int                              written_q    [$];               // Flat index of those cells
    dram_host_pkg::host_rsp_t        exp_q        [$];               // Responses still expected
    int                              row_a        [NB];
    int                              row_b        [NB];
    logic [31:0] stim_state    = SEED;
    logic [31:0] delay_state   = SEED;  // Separate stream for the host slot timing
    int          sent          = 0;
    int          received      = 0;
    int          returned      = 0;     // Response credits handed back by the host
    int          credit_pulses = 0;     // Request credits seen from the DUT
    int          hit_count     = 0;
    int          credit_delay  = 0;
    logic        hold_credits  = 1'b0;
    logic        run_done      = 1'b0;
    logic        fail_reported = 1'b0;

    dram_subsys #(
        .REQ_DEPTH(REQ_DEPTH), .RSP_CREDITS(RSP_CREDITS), .RSP_DEPTH(RSP_DEPTH),
        .T_RCD(T_RCD), .T_RP(T_RP)
    ) i_dut (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req(req), .req_credit(req_credit),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_credit(rsp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_word();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    function automatic int unsigned stim_rand(input int unsigned n);
        stim_state = lcg_step(stim_state);
        return (stim_state >> 8) % n;  // Low bits of an LCG repeat too quickly
    endfunction

    // Open-page rule: hit only when the addressed row is the one left open in that bank
    function automatic dram_host_pkg::host_rsp_t model_access(input dram_host_pkg::host_req_t r);
        dram_host_pkg::host_rsp_t e;
        e.hit   = ref_open_vld[r.bank] && (ref_open_row[r.bank] == r.row);
        e.we    = r.we;
        e.rdata = r.we ? '0 : ref_mem[r.bank][r.row][r.col];
        if (r.we) begin
            ref_mem[r.bank][r.row][r.col] = r.wdata;
        end
        ref_open_vld[r.bank] = 1'b1;  // Row stays open until the bank needs another
        ref_open_row[r.bank] = r.row;
        return e;
    endfunction

    task automatic abort_run(input string why);
        fail_reported = 1'b1;
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want));
    endtask

    // Called at a falling edge, returns at the next one with req_valid low
    task automatic send_req(input logic we, input int bank, input int row, input int col,
                            input logic [31:0] wdata);
        dram_host_pkg::host_req_t r;
        while (sent - credit_pulses >= REQ_DEPTH) begin
            req_valid = 1'b0;  // Out of credits, wait for the DUT to free a slot
            @(negedge clk);
        end
        r.we    = we;
        r.bank  = dram_geom_pkg::BANK_W'(bank);
        r.row   = dram_geom_pkg::ROW_W'(row);
        r.col   = dram_geom_pkg::COL_W'(col);
        r.wdata = we ? wdata : '0;
        if (we && !written[bank][row][col]) begin
            written[bank][row][col] = 1'b1;
            written_q.push_back((bank * ROWS + row) * COLS + col);
        end
        exp_q.push_back(model_access(r));
        req       = r;
        req_valid = 1'b1;
        sent++;
        @(negedge clk);
        req_valid = 1'b0;  // Next call in the same step drives it again without a gap
    endtask

    // Writes go anywhere, reads only to cells that hold defined data
    task automatic send_random(input logic we);
        int idx;
        if (we) begin
            idx = int'(stim_rand(NB * ROWS * COLS));
        end else begin
            idx = written_q[stim_rand(written_q.size())];
        end
        send_req(we, idx / (ROWS * COLS), (idx / COLS) % ROWS, idx % COLS, stim_word());
    endtask

    task automatic wait_drain();
        while (received != sent) @(negedge clk);
    endtask

    initial begin : stimulus
        int base_rx;
        int base_hits;
        int row_x;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int b = 0; b < NB; b++) begin
            row_a[b] = int'(stim_rand(ROWS));
            row_b[b] = (row_a[b] + 1 + int'(stim_rand(ROWS - 1))) % ROWS;  // Never equal to row_a
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (6) begin  // Quiet outputs before the first request
            @(negedge clk);
            assert (req_credit === 1'b0) else value_error("req_credit", 32'(req_credit), 32'h0);
            assert (rsp_valid === 1'b0) else value_error("rsp_valid", 32'(rsp_valid), 32'h0);
        end
        for (int b = 0; b < NB; b++) begin  // Two full rows per bank
            for (int c = 0; c < COLS; c++) send_req(1'b1, b, row_a[b], c, stim_word());
            for (int c = 0; c < COLS; c++) send_req(1'b1, b, row_b[b], c, stim_word());
        end
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < COLS; c++) send_req(1'b0, b, row_a[b], c, 32'h0);
            for (int c = 0; c < COLS; c++) send_req(1'b0, b, row_b[b], c, 32'h0);
        end
        wait_drain();
        base_hits = hit_count;  // Bank 2 has row_b open here, so a miss, three hits, a miss
        send_req(1'b0, 2, row_a[2], 0, 32'h0);
        send_req(1'b0, 2, row_a[2], 1, 32'h0);
        send_req(1'b1, 2, row_a[2], 1, stim_word());
        send_req(1'b0, 2, row_a[2], 1, 32'h0);
        send_req(1'b0, 2, row_b[2], 0, 32'h0);
        wait_drain();
        assert (hit_count - base_hits == 3)
            else value_error("hit count", 32'(hit_count - base_hits), 32'd3);
        row_x = row_a[1] ^ (ROWS / 2);  // Forces a precharge between the two rows
        send_req(1'b1, 1, row_a[1], 3, stim_word());
        send_req(1'b1, 1, row_x, 0, stim_word());
        send_req(1'b0, 1, row_a[1], 3, 32'h0);
        send_req(1'b0, 1, row_x, 0, 32'h0);
        wait_drain();
        while (returned != received) @(negedge clk);
        repeat (2) @(negedge clk);  // Let the last credit reach the DUT counter
        hold_credits = 1'b1;
        base_rx      = received;
        repeat (BP_FILL) send_random(1'b0);
        repeat (HOLD_CYCLES) @(negedge clk);
        assert (received - base_rx == RSP_CREDITS)
            else value_error("responses during stall", 32'(received - base_rx), 32'(RSP_CREDITS));
        assert (sent - credit_pulses == REQ_DEPTH)
            else value_error("requests held", 32'(sent - credit_pulses), 32'(REQ_DEPTH));
        hold_credits = 1'b0;
        repeat (4) send_random(1'b0);
        wait_drain();
        repeat (RAND_REQS) send_random(stim_rand(2) == 1);
        wait_drain();
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || credit_pulses != sent) begin
            abort_run($sformatf("run ended with %0d responses missing and %0d of %0d credits back",
                                exp_q.size(), credit_pulses, sent));
        end else begin
            run_done = 1'b1;
            $display("*** PASSED ***");
            $finish;
        end
    end

    // Values are taken at the rising edge, before the DUT updates
    always @(posedge clk) begin : compare
        dram_host_pkg::host_rsp_t exp;
        if (arst_n && rsp_valid) begin
            assert (exp_q.size() != 0) else abort_run("response arrived with no request outstanding");
            assert (RSP_CREDITS - received + returned > 0)
                else abort_run("response arrived while every host slot was taken");
            exp = exp_q.pop_front();
            assert (rsp.hit === exp.hit) else value_error("rsp.hit", 32'(rsp.hit), 32'(exp.hit));
            assert (rsp.we === exp.we) else value_error("rsp.we", 32'(rsp.we), 32'(exp.we));
            assert (rsp.rdata === exp.rdata) else value_error("rsp.rdata", rsp.rdata, exp.rdata);
            received++;
            if (rsp.hit) hit_count++;
        end
        if (arst_n && req_credit) credit_pulses++;  // One pulse per popped request
    end

    // Host frees one slot at a time after a random hold
    initial begin : credit_return
        rsp_credit = 1'b0;
        forever begin
            @(negedge clk);
            rsp_credit = 1'b0;
            if (arst_n && !hold_credits && returned < received) begin
                if (credit_delay == 0) begin
                    rsp_credit   = 1'b1;
                    returned++;
                    delay_state  = lcg_step(delay_state);
                    credit_delay = int'(delay_state[15:8]) % (MAX_CREDIT_DELAY + 1);
                end else begin
                    credit_delay--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run($sformatf("test did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // A checker assertion can stop the run before either message
    final begin
        if (!run_done && !fail_reported) begin
            $display("run stopped before the end of the test");
            $display("*** FAILED ***");
        end
    end

endmodule

`default_nettype wire

/* verification/dram_subsys_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_subsys_chk #(
    parameter int RSP_CREDITS = 2,
    parameter int CRD_W       = 2
) (
    input logic             clk,
    input logic             arst_n,
    input logic             req_credit,
    input logic             rsp_valid,
    input logic             rsp_push,
    input logic             rsp_credit,
    input logic [CRD_W-1:0] rsp_credits
);

    int slots_free;  // Host slots rebuilt from the handshake pulses alone
    int rsp_held;    // Responses pushed and not yet sent to the host

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slots_free <= RSP_CREDITS;
            rsp_held   <= 0;
        end else begin
            slots_free <= slots_free - int'(rsp_valid) + int'(rsp_credit);
            rsp_held   <= rsp_held + int'(rsp_push) - int'(rsp_valid);
        end
    end

    // The host never hands back more slots than it owns
    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_credits <= CRD_W'(RSP_CREDITS))
        else $error("response credit count above its starting value");

    // A response needs both a host slot and a queued entry
    a_valid_ok: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> (slots_free > 0) && (rsp_held > 0))
        else $error("rsp_valid without a host slot or without a queued response");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(arst_n) |-> !req_credit && !rsp_valid)
        else $error("req_credit or rsp_valid high right after reset");

endmodule

bind dram_ctrl dram_subsys_chk #(
    .RSP_CREDITS(RSP_CREDITS),
    .CRD_W(CRD_W)
) i_chk (
    .clk(clk), .arst_n(arst_n), .req_credit(req_credit), .rsp_valid(rsp_valid),
    .rsp_push(rsp_push), .rsp_credit(rsp_credit), .rsp_credits(rsp_credits)
);

`default_nettype wire

/* design/dram_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_subsys #(
    parameter int REQ_DEPTH   = 4,  // Also the host's starting request credits
    parameter int RSP_CREDITS = 2,  // Host response slots
    parameter int RSP_DEPTH   = 2,
    parameter int T_RCD       = 2,  // Idle cycles from ACT to RW
    parameter int T_RP        = 2   // Idle cycles from PRE to ACT
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req_valid,
    input  dram_host_pkg::host_req_t req,
    output logic                     req_credit,
    output logic                     rsp_valid,
    output dram_host_pkg::host_rsp_t rsp,
    input  logic                     rsp_credit
);

    dram_host_pkg::host_req_t                                       req_head;
    logic                                                           req_empty;
    logic                                                           req_pop;
    dram_geom_pkg::bank_cmd_t [dram_geom_pkg::NUM_BANKS-1:0]        bank_cmd;
    logic [dram_geom_pkg::NUM_BANKS-1:0][dram_geom_pkg::DATA_W-1:0] bank_rdata;
    dram_host_pkg::host_rsp_t                                       rsp_data;
    logic                                                           rsp_push;
    logic                                                           rsp_pop;
    logic                                                           rsp_full;
    logic                                                           rsp_empty;

    // Credits keep the host from ever pushing into a full request queue
    dram_queue #(.payload_t(dram_host_pkg::host_req_t), .DEPTH(REQ_DEPTH)) i_req_queue (
        .clk(clk), .arst_n(arst_n),
        .push(req_valid), .push_data(req),
        .pop(req_pop), .pop_data(req_head),
        .full(), .empty(req_empty)
    );

    dram_queue #(.payload_t(dram_host_pkg::host_rsp_t), .DEPTH(RSP_DEPTH)) i_rsp_queue (
        .clk(clk), .arst_n(arst_n),
        .push(rsp_push), .push_data(rsp_data),
        .pop(rsp_pop), .pop_data(rsp),
        .full(rsp_full), .empty(rsp_empty)
    );

    dram_ctrl #(.REQ_DEPTH(REQ_DEPTH), .RSP_CREDITS(RSP_CREDITS), .T_RCD(T_RCD), .T_RP(T_RP)) i_ctrl (
        .clk(clk), .arst_n(arst_n),
        .req_head(req_head), .req_empty(req_empty), .req_pop(req_pop), .req_credit(req_credit),
        .bank_cmd(bank_cmd), .bank_rdata(bank_rdata),
        .rsp_push(rsp_push), .rsp_data(rsp_data), .rsp_full(rsp_full), .rsp_empty(rsp_empty),
        .rsp_pop(rsp_pop), .rsp_credit(rsp_credit), .rsp_valid(rsp_valid)
    );

    for (genvar b = 0; b < dram_geom_pkg::NUM_BANKS; b++) begin : g_bank
        dram_bank i_bank (
            .clk(clk), .arst_n(arst_n),
            .cmd(bank_cmd[b]), .rdata(bank_rdata[b])
        );
    end

endmodule

`default_nettype wire

/* design/dram_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_ctrl #(
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_CREDITS = 2,
    parameter int T_RCD       = 2,
    parameter int T_RP        = 2
) (
    input  logic                                                           clk,
    input  logic                                                           arst_n,
    input  dram_host_pkg::host_req_t                                       req_head,
    input  logic                                                           req_empty,
    output logic                                                           req_pop,
    output logic                                                           req_credit,
    output dram_geom_pkg::bank_cmd_t [dram_geom_pkg::NUM_BANKS-1:0]        bank_cmd,
    input  logic [dram_geom_pkg::NUM_BANKS-1:0][dram_geom_pkg::DATA_W-1:0] bank_rdata,
    output logic                                                           rsp_push,
    output dram_host_pkg::host_rsp_t                                       rsp_data,
    input  logic                                                           rsp_full,
    input  logic                                                           rsp_empty,
    output logic                                                           rsp_pop,
    input  logic                                                           rsp_credit,
    output logic                                                           rsp_valid
);

    localparam int T_MAX  = (T_RP > T_RCD) ? T_RP : T_RCD;  // Longest wait to count
    localparam int WAIT_W = $clog2(T_MAX + 2);               // Room for the command cycle
    localparam int CRD_W  = $clog2(RSP_CREDITS + 1);         // Credits run 0..RSP_CREDITS

    // Without credits on either side the host could never make progress
    if (REQ_DEPTH < 1 || RSP_CREDITS < 1) begin : g_credit_check
        $error("dram_ctrl needs at least one request and one response credit");
    end

    typedef enum logic [2:0] {
        IDLE,
        PRECHARGE,
        ACTIVATE,
        ACCESS,
        RESPOND
    } state_e;

    state_e                                                         state;
    dram_host_pkg::host_req_t                                       cur;          // Request in work
    logic                                                           cur_hit;      // Hit at pop time
    logic [WAIT_W-1:0]                                              wait_cnt;     // Cycles in state
    logic [dram_geom_pkg::NUM_BANKS-1:0]                            open_vld;     // Bank has a row open
    logic [dram_geom_pkg::NUM_BANKS-1:0][dram_geom_pkg::ROW_W-1:0]  open_row;     // Which row
    logic [CRD_W-1:0]                                               rsp_credits;  // Host slots free
    logic                                                           head_open;
    logic                                                           head_hit;
    dram_geom_pkg::bank_op_e                                        op;

    assign head_open = open_vld[req_head.bank];                                  // Bank busy with a row
    assign head_hit  = head_open && (open_row[req_head.bank] == req_head.row);
    assign req_pop   = (state == IDLE) && !req_empty && !rsp_full;  // Response slot is reserved

    // First cycle of PRECHARGE and ACTIVATE carries the command, the rest are the delay
    always_comb begin
        op = dram_geom_pkg::NOP;
        case (state)
            PRECHARGE: op = (wait_cnt == '0) ? dram_geom_pkg::PRE : dram_geom_pkg::NOP;
            ACTIVATE:  op = (wait_cnt == '0) ? dram_geom_pkg::ACT : dram_geom_pkg::NOP;
            ACCESS:    op = dram_geom_pkg::RW;
            default:   op = dram_geom_pkg::NOP;
        endcase
    end

    // Only the addressed bank sees the operation, the others get NOP
    always_comb begin
        for (int b = 0; b < dram_geom_pkg::NUM_BANKS; b++) begin
            bank_cmd[b].op    = (cur.bank == dram_geom_pkg::BANK_W'(b)) ? op : dram_geom_pkg::NOP;
            bank_cmd[b].row   = cur.row;
            bank_cmd[b].col   = cur.col;
            bank_cmd[b].we    = cur.we;
            bank_cmd[b].wdata = cur.wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            wait_cnt   <= '0;
            open_vld   <= '0;          // Every row closed after reset
            req_credit <= 1'b0;
        end else begin
            req_credit <= req_pop;     // Credit goes back the cycle after the pop
            case (state)
                IDLE: begin
                    wait_cnt <= '0;
                    if (req_pop) begin
                        if (head_hit) begin
                            state <= ACCESS;      // Row already open
                        end else if (head_open) begin
                            state <= PRECHARGE;   // Wrong row open, close it first
                        end else begin
                            state <= ACTIVATE;    // Bank closed
                        end
                    end
                end
                PRECHARGE: begin
                    if (wait_cnt == WAIT_W'(T_RP)) begin
                        state    <= ACTIVATE;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ACTIVATE: begin
                    if (wait_cnt == WAIT_W'(T_RCD)) begin
                        state    <= ACCESS;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ACCESS:  state <= RESPOND;        // Read word arrives next cycle
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
            if (op == dram_geom_pkg::PRE) begin
                open_vld[cur.bank] <= 1'b0;
            end else if (op == dram_geom_pkg::ACT) begin
                open_vld[cur.bank] <= 1'b1;
            end
        end
    end

    // Request copy and open row numbers
    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur     <= req_head;
            cur_hit <= head_hit;
        end
        if (op == dram_geom_pkg::ACT) begin
            open_row[cur.bank] <= cur.row;
        end
    end

    assign rsp_push = (state == RESPOND);  // One cycle after RW

    always_comb begin
        rsp_data.hit   = cur_hit;
        rsp_data.we    = cur.we;
        rsp_data.rdata = cur.we ? '0 : bank_rdata[cur.bank];  // Writes return zero
    end

    // A response leaves only when the host has a slot for it
    assign rsp_valid = (rsp_credits != '0) && !rsp_empty;
    assign rsp_pop   = rsp_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_credits <= CRD_W'(RSP_CREDITS);
        end else begin
            case ({rsp_pop, rsp_credit})
                2'b10:   rsp_credits <= rsp_credits - 1'b1;  // Slot taken
                2'b01:   rsp_credits <= rsp_credits + 1'b1;  // Slot freed by the host
                default: rsp_credits <= rsp_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dram_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_bank (
    input  logic                              clk,
    input  logic                              arst_n,
    input  dram_geom_pkg::bank_cmd_t          cmd,
    output logic [dram_geom_pkg::DATA_W-1:0]  rdata
);

    localparam int ROWS = 2 ** dram_geom_pkg::ROW_W;  // Rows in the array
    localparam int COLS = 2 ** dram_geom_pkg::COL_W;  // Words per row

    logic [dram_geom_pkg::DATA_W-1:0] mem     [ROWS][COLS];  // Cell array
    logic [dram_geom_pkg::DATA_W-1:0] row_buf [COLS];        // Sense amplifier row
    logic [dram_geom_pkg::ROW_W-1:0]  open_row;              // Row held in row_buf
    logic                             buf_valid;             // row_buf holds a live row
    logic                             do_act;
    logic                             do_pre;
    logic                             do_rw;

    assign do_act = (cmd.op == dram_geom_pkg::ACT);
    assign do_pre = (cmd.op == dram_geom_pkg::PRE);
    assign do_rw  = (cmd.op == dram_geom_pkg::RW);

    // Open row bookkeeping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;         // Nothing open after reset
            open_row  <= '0;
        end else if (do_act) begin
            buf_valid <= 1'b1;
            open_row  <= cmd.row;      // Remember where the buffer goes back to
        end else if (do_pre) begin
            buf_valid <= 1'b0;         // Row closed once written back
        end
    end

    // Data movement between array, row buffer and read port
    always_ff @(posedge clk) begin
        if (do_act) begin
            for (int c = 0; c < COLS; c++) begin
                row_buf[c] <= mem[cmd.row][c];     // Whole row sensed at once
            end
        end
        if (do_pre && buf_valid) begin
            for (int c = 0; c < COLS; c++) begin
                mem[open_row][c] <= row_buf[c];    // Restore the row, writes included
            end
        end
        if (do_rw) begin
            if (cmd.we) begin
                row_buf[cmd.col] <= cmd.wdata;     // Writes land in the buffer only
            end else begin
                rdata <= row_buf[cmd.col];         // Word shows up one cycle after RW
            end
        end
    end

endmodule

`default_nettype wire

/* design/dram_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Slot index width
    localparam int CNT_W = $clog2(DEPTH + 1);                // Occupancy reaches DEPTH

    payload_t         slots [DEPTH];  // Circular storage
    logic [PTR_W-1:0] wr_ptr;         // Next slot to fill
    logic [PTR_W-1:0] rd_ptr;         // Current head slot
    logic [CNT_W-1:0] count;          // Entries held
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH so depths that are not a power of two work as well
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;      // A push into a full queue is dropped
    assign do_pop   = pop && !empty;      // Likewise a pop from an empty one
    assign pop_data = slots[rd_ptr];      // Head is visible without a register stage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;  // Fill only
                2'b01:   count <= count - 1'b1;  // Drain only
                default: count <= count;         // Both or neither keeps the level
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;          // Entry readable from the next cycle
        end
    end

endmodule

`default_nettype wire

/* design/dram_host_pkg.sv */
`default_nettype none

package dram_host_pkg;

    // One host request as it sits in the request queue
    typedef struct packed {
        logic                               we;     // Write when high, read when low
        logic [dram_geom_pkg::BANK_W-1:0]   bank;   // Target bank
        logic [dram_geom_pkg::ROW_W-1:0]    row;    // Target row inside the bank
        logic [dram_geom_pkg::COL_W-1:0]    col;    // Word inside the row
        logic [dram_geom_pkg::DATA_W-1:0]   wdata;  // Ignored for reads
    } host_req_t;                                   // 42 bits in total

    // One response per request, returned in request order
    typedef struct packed {
        logic                               hit;    // Row was already open at pop time
        logic                               we;     // Copy of the request direction
        logic [dram_geom_pkg::DATA_W-1:0]   rdata;  // Read word, zero for writes
    } host_rsp_t;                                   // 34 bits in total

endpackage

`default_nettype wire

/* design/dram_geom_pkg.sv */
`default_nettype none

package dram_geom_pkg;

    localparam int NUM_BANKS = 4;   // Banks served by the one controller
    localparam int BANK_W    = 2;   // Bank select width, matches NUM_BANKS
    localparam int ROW_W     = 4;   // Sixteen rows per bank
    localparam int COL_W     = 3;   // Eight words per row
    localparam int DATA_W    = 32;  // Word width of array and host data

    // Command a bank sees in a single cycle; NOP fills every other cycle
    typedef enum logic [1:0] {
        NOP = 2'd0,                 // Bank holds its state
        ACT = 2'd1,                 // Copy one array row into the row buffer
        PRE = 2'd2,                 // Write the row buffer back and close it
        RW  = 2'd3                  // Read or write one word of the open row
    } bank_op_e;

    typedef struct packed {
        bank_op_e          op;      // Operation for this cycle
        logic [ROW_W-1:0]  row;     // Row to open, only looked at on ACT
        logic [COL_W-1:0]  col;     // Word inside the open row for RW
        logic              we;      // High for a write on RW
        logic [DATA_W-1:0] wdata;   // Write word for RW with we high
    } bank_cmd_t;                   // 42 bits in total

endpackage

`default_nettype wire
